//--- all.f
+incdir+common
common/uart_cfg_pkg.sv
common/uart_rx_pkg.sv
logic/uart_rx_sampler.sv
rx_frame/rx_frame_fsm.sv
rx_fifo/rx_char_fifo.sv
logic/uart_rx.sv
verif/uart_rx_properties.sv
verif/tb_uart_rx.sv

//--- common/uart_cfg_pkg.sv
package uart_cfg_pkg;

  // Data bits per character, 5 + code
  typedef logic [1:0] word_len_t;

  // Parity bit rule when parity is enabled
  typedef enum logic [1:0] {
    PAR_ODD    = 2'b00,  // Data plus parity has odd weight
    PAR_EVEN   = 2'b01,
    PAR_FORCE1 = 2'b10,  // Stick parity, always 1
    PAR_FORCE0 = 2'b11   // Stick parity, always 0
  } parity_mode_e;

  // FIFO fill level that raises the trigger
  typedef enum logic [1:0] {
    TRIG_1  = 2'b00,
    TRIG_4  = 2'b01,
    TRIG_8  = 2'b10,
    TRIG_14 = 2'b11
  } trig_level_e;

  // Line format, held steady while the line is idle
  typedef struct packed {
    word_len_t    word_len;
    logic         par_en;    // Parity bit present
    parity_mode_e par_mode;
  } line_cfg_t;

endpackage

//--- common/uart_rx_params.svh
`ifndef UART_RX_PARAMS_SVH
`define UART_RX_PARAMS_SVH

// Oversample ticks per serial bit
`define UART_RX_OVERSAMPLE    16
// Timer count where a bit is handed to the framer
`define UART_RX_BIT_CENTER    8
// Majority samples at this count and the two after it
`define UART_RX_SAMPLE_FIRST  5
// Timer load when the start edge lands on a tick
`define UART_RX_START_OFFSET  2
`define UART_RX_SYNC_STAGES   2   // Metastability flops on rxd
`define UART_RX_FIFO_DEPTH    16  // Receive FIFO entries

`endif

//--- common/uart_rx_pkg.sv
`include "uart_rx_params.svh"

package uart_rx_pkg;

  // Oversample timer, one spare bit above the wrap value
  typedef logic [$clog2(`UART_RX_OVERSAMPLE):0] os_count_t;

  // Received character, upper bits zero for short words
  typedef logic [7:0] rx_data_t;

  // FIFO fill count, 0 up to full depth
  typedef logic [$clog2(`UART_RX_FIFO_DEPTH + 1)-1:0] fifo_usage_t;

  // One FIFO record, status above the data byte
  typedef struct packed {
    logic     par_err;    // Parity bit mismatch
    logic     frame_err;  // Stop bit sampled low
    logic     brk;        // Whole frame was zero
    rx_data_t data;
  } rx_char_t;

  // ----------------------------------------------------------
  // Framing FSM states
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    RX_IDLE   = 3'd0,  // Waiting for a falling edge
    RX_START  = 3'd1,  // Checking the start bit at its center
    RX_DATA   = 3'd2,
    RX_PAR    = 3'd3,
    RX_STOP   = 3'd4,
    RX_RESYNC = 3'd5   // One cycle after a bad stop bit
  } rx_state_e;

endpackage

//--- logic/uart_rx.sv
module uart_rx import uart_rx_pkg::*; import uart_cfg_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        oversample_edge_i,
  input  logic        rxd_i,
  input  line_cfg_t   line_cfg_i,
  input  trig_level_e trig_level_i,
  input  logic        fifo_flush_i,
  input  logic        rx_pop_i,
  output rx_char_t    rx_char_o,
  output logic        rx_empty_o,
  output logic        trigger_o,
  output logic        overrun_o
);

  logic     sync_rxd;
  logic     filt_bit;
  logic     bit_center;
  logic     hunt;
  logic     char_push;
  rx_char_t char_rec;

  // Line sampling
  uart_rx_sampler i_sampler (
    .clk_i,
    .reset_i,
    .oversample_edge_i,
    .rxd_i,
    .hunt_i       (hunt),
    .sync_rxd_o   (sync_rxd),
    .bit_o        (filt_bit),
    .bit_center_o (bit_center)
  );

  // Start, data, parity and stop bits
  rx_frame_fsm i_frame (
    .clk_i,
    .reset_i,
    .sync_rxd_i   (sync_rxd),
    .bit_i        (filt_bit),
    .bit_center_i (bit_center),
    .line_cfg_i,
    .hunt_o       (hunt),
    .char_push_o  (char_push),
    .char_rec_o   (char_rec)
  );

  rx_char_fifo i_fifo (
    .clk_i,
    .reset_i,
    .push_i       (char_push),
    .push_char_i  (char_rec),
    .pop_i        (rx_pop_i),
    .flush_i      (fifo_flush_i),
    .trig_level_i,
    .head_o       (rx_char_o),
    .empty_o      (rx_empty_o),
    .trigger_o,
    .overrun_o
  );

endmodule

//--- logic/uart_rx_sampler.sv
`include "uart_rx_params.svh"

module uart_rx_sampler import uart_rx_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic oversample_edge_i,  // One-clock tick, 16 per bit
  input  logic rxd_i,              // Raw serial line
  input  logic hunt_i,             // Framer is looking for a start edge
  output logic sync_rxd_o,
  output logic bit_o,              // Majority-filtered bit
  output logic bit_center_o
);

  localparam int unsigned SyncStages   = `UART_RX_SYNC_STAGES;
  localparam os_count_t   WrapCount    = os_count_t'(`UART_RX_OVERSAMPLE - 1);
  localparam os_count_t   BitCenter    = os_count_t'(`UART_RX_BIT_CENTER);
  localparam os_count_t   SampleFirst  = os_count_t'(`UART_RX_SAMPLE_FIRST);
  localparam os_count_t   SampleSecond = os_count_t'(`UART_RX_SAMPLE_FIRST + 1);
  localparam os_count_t   SampleLast   = os_count_t'(`UART_RX_SAMPLE_FIRST + 2);
  localparam os_count_t   StartOffset  = os_count_t'(`UART_RX_START_OFFSET);

  logic [SyncStages-1:0] sync_q;
  os_count_t             count_q;
  logic [1:0]            high_count_q;  // Ones among the first two samples
  logic                  majority;
  logic                  at_center;
  logic                  at_center_q;

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q <= '1;  // Line idles high
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], rxd_i};
    end
  end

  assign sync_rxd_o = sync_q[SyncStages-1];

  // ----------------------------------------------------------
  // Bit timer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (hunt_i) begin
      // Start edge on a tick is already partly into the bit
      if (!sync_rxd_o && oversample_edge_i) begin
        count_q <= StartOffset;
      end else begin
        count_q <= '0;
      end
    end else if (oversample_edge_i) begin
      if (count_q == WrapCount) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Three-sample majority filter
  // ----------------------------------------------------------
  // Two of three high gives a one
  assign majority = (high_count_q + {1'b0, sync_rxd_o}) >= 2'd2;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      high_count_q <= '0;
      bit_o        <= 1'b1;
    end else if (oversample_edge_i && !hunt_i) begin
      if (count_q == SampleFirst) begin
        high_count_q <= {1'b0, sync_rxd_o};  // Restart the tally
      end else if (count_q == SampleSecond) begin
        high_count_q <= high_count_q + {1'b0, sync_rxd_o};
      end else if (count_q == SampleLast) begin
        bit_o <= majority;  // Third sample decides
      end
    end
  end

  // Timer sits at the center for a whole tick period, pulse once
  assign at_center = (count_q == BitCenter);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      at_center_q  <= 1'b0;
      bit_center_o <= 1'b0;
    end else begin
      at_center_q  <= at_center;
      bit_center_o <= at_center && !at_center_q;
    end
  end

endmodule

//--- rx_fifo/rx_char_fifo.sv
`include "uart_rx_params.svh"

module rx_char_fifo import uart_rx_pkg::*; import uart_cfg_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        push_i,
  input  rx_char_t    push_char_i,
  input  logic        pop_i,         // Ignored when empty
  input  logic        flush_i,
  input  trig_level_e trig_level_i,
  output rx_char_t    head_o,        // Oldest character, no read latency
  output logic        empty_o,
  output logic        trigger_o,
  output logic        overrun_o
);

  localparam int unsigned Depth    = `UART_RX_FIFO_DEPTH;
  localparam int unsigned PtrWidth = $clog2(Depth);

  typedef logic [PtrWidth-1:0] fifo_ptr_t;

  rx_char_t    mem_q [Depth];
  fifo_ptr_t   wr_ptr_q;
  fifo_ptr_t   rd_ptr_q;
  fifo_usage_t usage_q;
  fifo_usage_t threshold;
  logic        full;
  logic        do_push;
  logic        do_pop;

  function automatic fifo_ptr_t ptr_next(fifo_ptr_t ptr);
    ptr_next = (ptr == fifo_ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (usage_q == fifo_usage_t'(Depth));
  assign empty_o = (usage_q == '0);
  assign do_push = push_i && !full;   // Full FIFO drops the new one
  assign do_pop  = pop_i && !empty_o;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_char_i;
    end
  end

  // ----------------------------------------------------------
  // Pointers and fill count
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overrun_o <= 1'b0;
    end else begin
      overrun_o <= push_i && full;  // One clock per lost character
    end
  end

  // ----------------------------------------------------------
  // Trigger level
  // ----------------------------------------------------------
  always_comb begin
    case (trig_level_i)
      TRIG_1:  threshold = fifo_usage_t'(1);
      TRIG_4:  threshold = fifo_usage_t'(4);
      TRIG_8:  threshold = fifo_usage_t'(8);
      TRIG_14: threshold = fifo_usage_t'(14);
      default: threshold = fifo_usage_t'(1);
    endcase
  end

  assign trigger_o = (usage_q >= threshold);

endmodule

//--- rx_frame/rx_frame_fsm.sv
module rx_frame_fsm import uart_rx_pkg::*; import uart_cfg_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      sync_rxd_i,    // Line level for start detection
  input  logic      bit_i,         // Filtered bit value
  input  logic      bit_center_i,  // One pulse per bit
  input  line_cfg_t line_cfg_i,
  output logic      hunt_o,
  output logic      char_push_o,
  output rx_char_t  char_rec_o
);

  rx_state_e  state_q;
  rx_state_e  state_d;
  logic [2:0] bit_cnt_q;  // Index of the next data bit
  logic [2:0] last_bit;
  rx_data_t   data_q;
  logic       par_err_q;
  logic       any_one_q;  // Some data or parity bit was high
  logic       par_bad;

  // Word length code 0..3 maps to last index 4..7
  assign last_bit = {1'b1, line_cfg_i.word_len};

  // Sampler waits for a start edge in these states
  assign hunt_o = (state_q == RX_IDLE) || (state_q == RX_RESYNC);

  // ----------------------------------------------------------
  // Parity check on the current bit
  // ----------------------------------------------------------
  always_comb begin
    case (line_cfg_i.par_mode)
      PAR_ODD:    par_bad = ~(^data_q ^ bit_i);
      PAR_EVEN:   par_bad = ^data_q ^ bit_i;
      PAR_FORCE1: par_bad = ~bit_i;
      PAR_FORCE0: par_bad = bit_i;
      default:    par_bad = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: begin
        if (!sync_rxd_i) begin
          state_d = RX_START;
        end
      end
      RX_START: begin
        if (bit_center_i) begin
          state_d = bit_i ? RX_IDLE : RX_DATA;  // High at center was a glitch
        end
      end
      RX_DATA: begin
        if (bit_center_i && (bit_cnt_q == last_bit)) begin
          state_d = line_cfg_i.par_en ? RX_PAR : RX_STOP;
        end
      end
      RX_PAR: begin
        if (bit_center_i) begin
          state_d = RX_STOP;
        end
      end
      RX_STOP: begin
        if (bit_center_i) begin
          state_d = bit_i ? RX_IDLE : RX_RESYNC;
        end
      end
      RX_RESYNC: begin
        // Low line is taken as the next start bit
        state_d = sync_rxd_i ? RX_IDLE : RX_START;
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= RX_IDLE;
      bit_cnt_q   <= '0;
      char_push_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      char_push_o <= (state_q == RX_STOP) && bit_center_i;  // Frame done
      if (state_q == RX_START) begin
        bit_cnt_q <= '0;
      end else if ((state_q == RX_DATA) && bit_center_i) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Character assembly
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (bit_center_i) begin
      case (state_q)
        RX_START: begin
          data_q    <= '0;  // Unused upper bits stay zero
          par_err_q <= 1'b0;
          any_one_q <= 1'b0;
        end
        RX_DATA: begin
          data_q[bit_cnt_q] <= bit_i;  // LSB first
          any_one_q         <= any_one_q | bit_i;
        end
        RX_PAR: begin
          par_err_q <= par_bad;
          any_one_q <= any_one_q | bit_i;
        end
        RX_STOP: begin
          char_rec_o.par_err   <= par_err_q;
          char_rec_o.frame_err <= !bit_i;
          char_rec_o.brk       <= !any_one_q && !bit_i;  // Stop bit low too
          char_rec_o.data      <= data_q;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- verif/tb_uart_rx.sv
`include "uart_rx_params.svh"

module tb_uart_rx import uart_rx_pkg::*, uart_cfg_pkg::*; ();

  localparam int BitClocks = 4 * `UART_RX_OVERSAMPLE;  // Tick every fourth clock
  localparam int Depth     = `UART_RX_FIFO_DEPTH;
  localparam int NumRandom = 48;
  localparam int NumFrames = 2 * NumRandom + 27 + 17 + 3;  // Error frames count twice
  localparam int MaxCycles = NumFrames * 12 * BitClocks + 2000;

  logic        clk_i;
  logic        reset_i;
  logic        oversample_edge_i;
  logic        rxd_i;
  line_cfg_t   line_cfg_i;
  trig_level_e trig_level_i;
  logic        fifo_flush_i;
  logic        rx_pop_i;
  rx_char_t    rx_char_o;
  logic        rx_empty_o;
  logic        trigger_o;
  logic        overrun_o;

  logic [31:0] lcg_state = 32'h28cd;
  rx_char_t    exp_q[$];          // Model of the FIFO contents
  int          exp_overruns = 0;
  int          overrun_seen = 0;
  int          cycles = 0;
  logic [1:0]  tick_phase = '0;

  uart_rx UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Oversample strobe, one clock in four
  initial begin
    oversample_edge_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      tick_phase        = tick_phase + 1'b1;
      oversample_edge_i = (tick_phase == 2'd0);
    end
  end

  // Overrun pulses and run limit, sampled mid-cycle
  always @(negedge clk_i) begin
    cycles = cycles + 1;
    if (overrun_o === 1'b1) begin
      overrun_seen = overrun_seen + 1;
    end
    if (cycles > MaxCycles) begin
      $display("Run timed out after %0d cycles before the tests completed", cycles);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------------------------
  // Random numbers and reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rx_data_t word_mask(word_len_t len);
    return 8'hff >> (2'd3 - len);  // Code 3 keeps all eight bits
  endfunction

  // Parity bit a correct transmitter would send
  function automatic logic parity_for(line_cfg_t cfg, rx_data_t data);
    case (cfg.par_mode)
      PAR_ODD:    return ~^data;
      PAR_EVEN:   return ^data;
      PAR_FORCE1: return 1'b1;
      default:    return 1'b0;
    endcase
  endfunction

  function automatic rx_char_t model_char(line_cfg_t cfg, rx_data_t data, logic par,
                                          logic stop);
    rx_char_t c;
    c.data      = data & word_mask(cfg.word_len);
    c.par_err   = cfg.par_en && (par != parity_for(cfg, c.data));
    c.frame_err = !stop;
    c.brk       = !stop && (c.data == '0) && !(cfg.par_en && par);  // Every bit low
    return c;
  endfunction

  // Full FIFO loses the character
  function automatic void note_char(rx_char_t c);
    if (exp_q.size() < Depth) begin
      exp_q.push_back(c);
    end else begin
      exp_overruns++;
    end
  endfunction

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h expected %h", $time, name, actual, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_clocks(int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  // ----------------------------------------------------------
  // Serial driver and FIFO reader
  // ----------------------------------------------------------
  task automatic send_frame(line_cfg_t cfg, rx_data_t data, logic par, logic stop);
    int i;
    rxd_i = 1'b0;  // Start bit
    wait_clocks(BitClocks);
    for (i = 0; i < 5 + cfg.word_len; i++) begin
      rxd_i = data[i];  // LSB first
      wait_clocks(BitClocks);
    end
    if (cfg.par_en) begin
      rxd_i = par;
      wait_clocks(BitClocks);
    end
    rxd_i = stop;
    wait_clocks(BitClocks);
    rxd_i = 1'b1;
  endtask

  task automatic send_clean();
    logic [31:0] rnd;
    line_cfg_t   cfg;
    rx_data_t    data;
    rnd        = lcg_next();
    cfg        = rnd[24:20];
    data       = rnd[15:8] & word_mask(cfg.word_len);
    line_cfg_i = cfg;
    send_frame(cfg, data, parity_for(cfg, data), 1'b1);
    note_char(model_char(cfg, data, parity_for(cfg, data), 1'b1));
    wait_clocks(1 + rnd[31:27]);  // Random idle gap
  endtask

  task automatic pop_one();
    rx_char_t exp;
    while (rx_empty_o) begin
      wait_clocks(1);
    end
    exp = exp_q.pop_front();
    check_value("rx_char_o", rx_char_o, exp);
    rx_pop_i = 1'b1;
    wait_clocks(1);
    rx_pop_i = 1'b0;
  endtask

  task automatic check_levels(int thr);
    check_value("rx_empty_o", rx_empty_o, exp_q.size() == 0);
    check_value("trigger_o", trigger_o, exp_q.size() >= thr);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    int          f;
    int          lvl;
    int          thr;
    logic [31:0] rnd;
    line_cfg_t   cfg;
    rx_data_t    data;
    logic        par;
    logic        stop;
    reset_i      = 1'b1;
    rxd_i        = 1'b1;  // Idle line
    line_cfg_i   = '0;
    trig_level_i = TRIG_1;
    fifo_flush_i = 1'b0;
    rx_pop_i     = 1'b0;
    wait_clocks(4);
    reset_i = 1'b0;
    check_levels(1);
    check_value("overrun_o", overrun_o, 0);

    // Clean, bad parity, bad stop and break frames
    for (f = 0; f < NumRandom; f++) begin
      data       = lcg_next() >> 24;
      rnd        = lcg_next();
      cfg        = rnd[24:20];
      data       = data & word_mask(cfg.word_len);
      stop       = (rnd[3:1] != 3'd0);                       // One in eight low
      par        = parity_for(cfg, data) ^ (rnd[6:5] == 2'd0);  // Some inverted
      if (!stop && rnd[4]) begin
        data = '0;
        par  = 1'b0;
      end
      line_cfg_i = cfg;
      send_frame(cfg, data, par, stop);
      note_char(model_char(cfg, data, par, stop));
      if (!stop) begin
        // Low stop bit is taken as a new start, idle line then reads as ones
        wait_clocks(12 * BitClocks);
        note_char(model_char(cfg, 8'hff, 1'b1, 1'b1));
      end else begin
        wait_clocks(1 + rnd[31:27]);
      end
      while (exp_q.size() > 0) begin
        pop_one();
      end
      check_levels(1);
    end

    // Trigger level per setting
    for (lvl = 0; lvl < 4; lvl++) begin
      trig_level_i = trig_level_e'(lvl);
      thr          = (lvl == 0) ? 1 : (lvl == 1) ? 4 : (lvl == 2) ? 8 : 14;
      repeat (thr) begin
        send_clean();
        check_levels(thr);
      end
      while (exp_q.size() > 0) begin
        pop_one();
        check_levels(thr);
      end
    end

    // Overrun on a full FIFO, then flush
    trig_level_i = TRIG_14;
    check_value("overrun pulses", overrun_seen, 0);
    repeat (Depth + 1) begin
      send_clean();
      check_levels(14);
    end
    check_value("overrun pulses", overrun_seen, exp_overruns);
    while (exp_q.size() > 0) begin
      pop_one();
    end
    check_levels(14);
    repeat (3) begin
      send_clean();
    end
    fifo_flush_i = 1'b1;
    wait_clocks(1);
    fifo_flush_i = 1'b0;
    exp_q.delete();
    check_levels(14);
    wait_clocks(10);

    if (UUT.props.fail_count != 0) begin
      $display("Bound assertions failed %0d times", UUT.props.fail_count);
      $display("Checks failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- verif/uart_rx_properties.sv
module uart_rx_properties import uart_rx_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input logic     fifo_flush_i,
  input logic     rx_pop_i,
  input rx_char_t rx_char_o,
  input logic     rx_empty_o,
  input logic     trigger_o,
  input logic     overrun_o
);

  int unsigned fail_count = 0;  // Failed assertion count

  // ----------------------------------------------------------
  // Output rules of the receive FIFO
  // ----------------------------------------------------------
  overrun_single: assert property (@(posedge clk_i) disable iff (reset_i)
    overrun_o |=> !overrun_o)
    else begin
      fail_count++;
      $error("overrun_o high for two clocks in a row");
    end

  // Trigger needs at least one character
  empty_no_trigger: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rx_empty_o && trigger_o))
    else begin
      fail_count++;
      $error("rx_empty_o and trigger_o high together");
    end

  head_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (!rx_empty_o && !rx_pop_i && !fifo_flush_i) |=> $stable(rx_char_o))
    else begin
      fail_count++;
      $error("rx_char_o changed without a pop or flush");
    end

endmodule

bind uart_rx uart_rx_properties props (.*);
